// File: src/proc_defs.svh
`ifndef PROC_DEFS_SVH
`define PROC_DEFS_SVH

// Data and instruction word
`define PROC_WORD_W     32

// Register file geometry
`define PROC_REG_IDX_W  5
`define PROC_NUM_REGS   32

//////////////////////////////
// Instruction fields
//////////////////////////////

// Opcode sits in the top bits of the word
`define PROC_OPC_W      6
`define PROC_OPC_LSB    26
`define PROC_RS_LSB     21
`define PROC_RT_LSB     16
`define PROC_RD_LSB     11

// Immediate starts at bit 0 and is sign extended
`define PROC_IMM_W      16

`endif

// File: src/isa_pkg.sv
`include "proc_defs.svh"

package isa_pkg;

   //////////////////////////////
   // Operand types
   //////////////////////////////

   typedef logic [`PROC_WORD_W-1:0]    word_t;
   typedef logic [`PROC_REG_IDX_W-1:0] reg_idx_t;

   // Raw immediate field before sign extension
   typedef logic [`PROC_IMM_W-1:0]     imm_t;

   //////////////////////////////
   // Opcodes
   //////////////////////////////

   // All-zero word decodes as NOP, so a cleared register is a bubble
   typedef enum logic [`PROC_OPC_W-1:0] {
      OP_NOP  = 6'h00,
      OP_HALT = 6'h01,
      OP_ADD  = 6'h02,
      OP_SUB  = 6'h03,
      OP_AND  = 6'h04,
      OP_XOR  = 6'h05,
      OP_ADDI = 6'h08,
      OP_LD   = 6'h10,
      OP_ST   = 6'h11
   } opcode_t;

endpackage

// File: src/pipe_pkg.sv
package pipe_pkg;

   // ALU function, loads and stores add for the address
   typedef enum logic [1:0] {
      ALU_ADD = 2'd0,
      ALU_SUB = 2'd1,
      ALU_AND = 2'd2,
      ALU_XOR = 2'd3
   } alu_op_t;

   // Where an execute operand comes from
   typedef enum logic [1:0] {
      FWD_REG = 2'd0,
      FWD_MEM = 2'd1,
      FWD_WB  = 2'd2
   } fwd_sel_t;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
   input  logic           clk,
   input  logic           rst_n,
   input  logic           stall_i,
   input  logic           halt_id_i,
   output isa_pkg::word_t iaddr_o,
   input  isa_pkg::word_t inst_i,
   output isa_pkg::word_t if_inst_o
);
   import isa_pkg::*;

   word_t pc_q;
   logic  stopped_q;
   logic  freeze;

   // HALT in decode already blocks this edge
   assign freeze  = stopped_q | halt_id_i;
   assign iaddr_o = pc_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stopped_q <= 1'b0;
      end else if (halt_id_i) begin
         stopped_q <= 1'b1;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc_q <= '0;
      end else if (!freeze && !stall_i) begin
         pc_q <= pc_q + word_t'(4);
      end
   end

   //////////////////////////////
   // IF/ID register
   //////////////////////////////

   // Zero is a NOP, so reset and halt both leave a bubble
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         if_inst_o <= '0;
      end else if (freeze) begin
         if_inst_o <= '0;
      end else if (!stall_i) begin
         if_inst_o <= inst_i;
      end
   end

   // HALT reads no register, so decode can never stall on it
   a_halt_not_stalled: assert property (@(posedge clk) disable iff (!rst_n)
      !(stall_i && halt_id_i))
      else $error("fetch: stall and halt raised together");

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module reg_file (
   input  logic              clk,
   input  logic              rst_n,
   input  isa_pkg::reg_idx_t rs_idx_i,
   input  isa_pkg::reg_idx_t rt_idx_i,
   output isa_pkg::word_t    rs_val_o,
   output isa_pkg::word_t    rt_val_o,
   input  logic              we_i,
   input  isa_pkg::reg_idx_t wr_idx_i,
   input  isa_pkg::word_t    wr_data_i
);
   import isa_pkg::*;

   word_t regs_q [`PROC_NUM_REGS];
   logic  wr_en;

   // r0 is never written
   assign wr_en = we_i && (wr_idx_i != '0);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `PROC_NUM_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (wr_en) begin
         regs_q[wr_idx_i] <= wr_data_i;
      end
   end

   // Read port with write-through from writeback
   function automatic word_t read_port(input reg_idx_t idx);
      if (idx == '0) begin
         return '0;
      end
      if (wr_en && (wr_idx_i == idx)) begin
         return wr_data_i;
      end
      return regs_q[idx];
   endfunction

   always_comb begin
      rs_val_o = read_port(rs_idx_i);
      rt_val_o = read_port(rt_idx_i);
   end

endmodule

// File: src/decode_stage.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module decode_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  isa_pkg::word_t    if_inst_i,
   output logic              stall_o,
   output logic              halt_id_o,
   output logic              err_o,
   input  logic              wb_we_i,
   input  isa_pkg::reg_idx_t wb_idx_i,
   input  isa_pkg::word_t    wb_data_i,
   output isa_pkg::reg_idx_t ex_rs_idx_o,
   output isa_pkg::reg_idx_t ex_rt_idx_o,
   output isa_pkg::reg_idx_t ex_dest_idx_o,
   output isa_pkg::word_t    ex_rs_val_o,
   output isa_pkg::word_t    ex_rt_val_o,
   output isa_pkg::word_t    ex_imm_o,
   output pipe_pkg::alu_op_t ex_alu_op_o,
   output logic              ex_use_imm_o,
   output logic              ex_dest_we_o,
   output logic              ex_is_load_o,
   output logic              ex_is_store_o,
   output logic              ex_is_halt_o
);
   import isa_pkg::*;
   import pipe_pkg::*;

   opcode_t  opcode;
   reg_idx_t rs_idx;
   reg_idx_t rt_idx;
   reg_idx_t rd_idx;
   reg_idx_t dest_idx;
   imm_t     imm_field;
   word_t    rs_val;
   word_t    rt_val;
   alu_op_t  alu_op;
   logic     legal;
   logic     uses_rs;
   logic     uses_rt;
   logic     dest_we;
   logic     use_imm;
   logic     is_load;
   logic     is_store;
   logic     is_halt;
   logic     live;

   assign opcode    = opcode_t'(if_inst_i[`PROC_OPC_LSB +: `PROC_OPC_W]);
   assign rs_idx    = if_inst_i[`PROC_RS_LSB +: `PROC_REG_IDX_W];
   assign rt_idx    = if_inst_i[`PROC_RT_LSB +: `PROC_REG_IDX_W];
   assign rd_idx    = if_inst_i[`PROC_RD_LSB +: `PROC_REG_IDX_W];
   assign imm_field = if_inst_i[`PROC_IMM_W-1:0];

   //////////////////////////////
   // Opcode decode
   //////////////////////////////

   always_comb begin
      legal    = 1'b1;
      uses_rs  = 1'b0;
      uses_rt  = 1'b0;
      dest_idx = rd_idx;
      dest_we  = 1'b0;
      alu_op   = ALU_ADD;
      use_imm  = 1'b0;
      is_load  = 1'b0;
      is_store = 1'b0;
      is_halt  = 1'b0;
      case (opcode)
         OP_NOP, OP_HALT: is_halt = (opcode == OP_HALT);
         OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
            uses_rs = 1'b1;
            uses_rt = 1'b1;
            dest_we = 1'b1;
            alu_op  = (opcode == OP_SUB) ? ALU_SUB :
                      (opcode == OP_AND) ? ALU_AND :
                      (opcode == OP_XOR) ? ALU_XOR : ALU_ADD;
         end
         // I-format writes rt
         OP_ADDI, OP_LD: begin
            uses_rs  = 1'b1;
            use_imm  = 1'b1;
            dest_idx = rt_idx;
            dest_we  = 1'b1;
            is_load  = (opcode == OP_LD);
         end
         OP_ST: begin
            uses_rs  = 1'b1;
            uses_rt  = 1'b1;
            use_imm  = 1'b1;
            is_store = 1'b1;
         end
         default: legal = 1'b0;
      endcase
   end

   // Load in EX whose result is needed here
   assign stall_o = ex_is_load_o && ex_dest_we_o &&
                    ((uses_rs && (rs_idx == ex_dest_idx_o)) ||
                     (uses_rt && (rt_idx == ex_dest_idx_o)));

   assign halt_id_o = is_halt;
   assign err_o     = !legal && !stall_o;
   // Illegal opcodes already decode with every control low
   assign live      = !stall_o;

   reg_file u_reg_file (
      .clk       (clk),
      .rst_n     (rst_n),
      .rs_idx_i  (rs_idx),
      .rt_idx_i  (rt_idx),
      .rs_val_o  (rs_val),
      .rt_val_o  (rt_val),
      .we_i      (wb_we_i),
      .wr_idx_i  (wb_idx_i),
      .wr_data_i (wb_data_i)
   );

   //////////////////////////////
   // ID/EX register
   //////////////////////////////

   // Index 0 marks an operand that is not read
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ex_rs_idx_o   <= '0;
         ex_rt_idx_o   <= '0;
         ex_dest_idx_o <= '0;
         ex_dest_we_o  <= 1'b0;
         ex_alu_op_o   <= ALU_ADD;
         ex_use_imm_o  <= 1'b0;
         ex_is_load_o  <= 1'b0;
         ex_is_store_o <= 1'b0;
         ex_is_halt_o  <= 1'b0;
      end else begin
         ex_rs_idx_o   <= (live && uses_rs) ? rs_idx : '0;
         ex_rt_idx_o   <= (live && uses_rt) ? rt_idx : '0;
         ex_dest_idx_o <= dest_idx;
         ex_dest_we_o  <= live && dest_we && (dest_idx != '0);
         ex_alu_op_o   <= alu_op;
         ex_use_imm_o  <= use_imm;
         ex_is_load_o  <= live && is_load;
         ex_is_store_o <= live && is_store;
         ex_is_halt_o  <= live && is_halt;
      end
   end

   always_ff @(posedge clk) begin
      ex_rs_val_o <= rs_val;
      ex_rt_val_o <= rt_val;
      ex_imm_o    <= {{(`PROC_WORD_W-`PROC_IMM_W){imm_field[`PROC_IMM_W-1]}}, imm_field};
   end

   a_bubble_is_inert: assert property (@(posedge clk) disable iff (!rst_n)
      (stall_o || err_o) |=> !ex_dest_we_o && !ex_is_store_o && !ex_is_load_o)
      else $error("decode: bubble entered ID/EX with live controls");

   a_load_not_store: assert property (@(posedge clk) disable iff (!rst_n)
      ex_is_load_o |-> !ex_is_store_o)
      else $error("decode: ID/EX entry is both load and store");

endmodule

// File: src/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  isa_pkg::reg_idx_t ex_rs_idx_i,
   input  isa_pkg::reg_idx_t ex_rt_idx_i,
   input  isa_pkg::reg_idx_t ex_dest_idx_i,
   input  isa_pkg::word_t    ex_rs_val_i,
   input  isa_pkg::word_t    ex_rt_val_i,
   input  isa_pkg::word_t    ex_imm_i,
   input  pipe_pkg::alu_op_t ex_alu_op_i,
   input  logic              ex_use_imm_i,
   input  logic              ex_dest_we_i,
   input  logic              ex_is_load_i,
   input  logic              ex_is_store_i,
   input  logic              ex_is_halt_i,
   input  logic              wb_we_i,
   input  isa_pkg::reg_idx_t wb_idx_i,
   input  isa_pkg::word_t    wb_data_i,
   output isa_pkg::word_t    mem_alu_res_o,
   output isa_pkg::word_t    mem_store_val_o,
   output isa_pkg::reg_idx_t mem_dest_idx_o,
   output logic              mem_dest_we_o,
   output logic              mem_is_load_o,
   output logic              mem_is_store_o,
   output logic              mem_is_halt_o
);
   import isa_pkg::*;
   import pipe_pkg::*;

   word_t    mem_fwd_val;
   fwd_sel_t fwd_a;
   fwd_sel_t fwd_b;
   word_t    opnd_a;
   word_t    rt_fwd;
   word_t    opnd_b;
   word_t    alu_res;

   // A load's value is not ready yet in EX/MEM
   assign mem_fwd_val = mem_alu_res_o;

   //////////////////////////////
   // Forwarding
   //////////////////////////////

   function automatic fwd_sel_t pick_src(input reg_idx_t idx);
      if (idx == '0) begin
         return FWD_REG;
      end
      if (mem_dest_we_o && !mem_is_load_o && (mem_dest_idx_o == idx)) begin
         return FWD_MEM;
      end
      if (wb_we_i && (wb_idx_i == idx)) begin
         return FWD_WB;
      end
      return FWD_REG;
   endfunction

   function automatic word_t fwd_mux(input fwd_sel_t sel, input word_t reg_val);
      case (sel)
         FWD_MEM: return mem_fwd_val;
         FWD_WB:  return wb_data_i;
         default: return reg_val;
      endcase
   endfunction

   always_comb begin
      fwd_a  = pick_src(ex_rs_idx_i);
      fwd_b  = pick_src(ex_rt_idx_i);
      opnd_a = fwd_mux(fwd_a, ex_rs_val_i);
      rt_fwd = fwd_mux(fwd_b, ex_rt_val_i);
      opnd_b = ex_use_imm_i ? ex_imm_i : rt_fwd;
   end

   always_comb begin
      case (ex_alu_op_i)
         ALU_SUB: alu_res = opnd_a - opnd_b;
         ALU_AND: alu_res = opnd_a & opnd_b;
         ALU_XOR: alu_res = opnd_a ^ opnd_b;
         default: alu_res = opnd_a + opnd_b;
      endcase
   end

   //////////////////////////////
   // EX/MEM register
   //////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         mem_dest_we_o  <= 1'b0;
         mem_is_load_o  <= 1'b0;
         mem_is_store_o <= 1'b0;
         mem_is_halt_o  <= 1'b0;
      end else begin
         mem_dest_we_o  <= ex_dest_we_i;
         mem_is_load_o  <= ex_is_load_i;
         mem_is_store_o <= ex_is_store_i;
         mem_is_halt_o  <= ex_is_halt_i;
      end
   end

   // Store data takes the forwarded rt
   always_ff @(posedge clk) begin
      mem_alu_res_o   <= alu_res;
      mem_store_val_o <= rt_fwd;
      mem_dest_idx_o  <= ex_dest_idx_i;
   end

   // Decode has to hold back any reader of a load still in MEM
   a_no_load_use: assert property (@(posedge clk) disable iff (!rst_n)
      (mem_is_load_o && mem_dest_we_o) |->
         (ex_rs_idx_i != mem_dest_idx_o) && (ex_rt_idx_i != mem_dest_idx_o))
      else $error("execute: load result used one cycle too early");

endmodule

// File: src/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage (
   input  logic              clk,
   input  logic              rst_n,
   input  isa_pkg::word_t    mem_alu_res_i,
   input  isa_pkg::word_t    mem_store_val_i,
   input  isa_pkg::reg_idx_t mem_dest_idx_i,
   input  logic              mem_dest_we_i,
   input  logic              mem_is_load_i,
   input  logic              mem_is_store_i,
   input  logic              mem_is_halt_i,
   output isa_pkg::word_t    daddr_o,
   output isa_pkg::word_t    data_o,
   output logic              we_o,
   output logic              re_o,
   input  isa_pkg::word_t    rdata_i,
   output logic              wb_we_o,
   output isa_pkg::reg_idx_t wb_idx_o,
   output isa_pkg::word_t    wb_data_o,
   output logic              halt_o
);
   import isa_pkg::*;

   word_t alu_res_q;
   word_t rdata_q;
   logic  is_load_q;

   // Data memory answers in the same cycle
   assign daddr_o = mem_alu_res_i;
   assign data_o  = mem_store_val_i;
   assign we_o    = mem_is_store_i;
   assign re_o    = mem_is_load_i;

   //////////////////////////////
   // MEM/WB register
   //////////////////////////////

   // halt_o stays up once HALT reaches writeback
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_we_o   <= 1'b0;
         wb_idx_o  <= '0;
         is_load_q <= 1'b0;
         halt_o    <= 1'b0;
      end else begin
         wb_we_o   <= mem_dest_we_i;
         wb_idx_o  <= mem_dest_idx_i;
         is_load_q <= mem_is_load_i;
         halt_o    <= halt_o | mem_is_halt_i;
      end
   end

   always_ff @(posedge clk) begin
      alu_res_q <= mem_alu_res_i;
      rdata_q   <= rdata_i;
   end

   assign wb_data_o = is_load_q ? rdata_q : alu_res_q;

endmodule

// File: src/proc.sv
`timescale 1ns/1ps

module proc (
   input  logic           clk,
   input  logic           rst_n,
   output isa_pkg::word_t iaddr_o,
   input  isa_pkg::word_t inst_i,
   output isa_pkg::word_t daddr_o,
   output isa_pkg::word_t data_o,
   output logic           we_o,
   output logic           re_o,
   input  isa_pkg::word_t rdata_i,
   output logic           err_o,
   output logic           halt_o
);
   import isa_pkg::*;
   import pipe_pkg::*;

   // Fetch and decode
   word_t    if_inst;
   logic     stall;
   logic     halt_id;

   // ID/EX
   reg_idx_t ex_rs_idx;
   reg_idx_t ex_rt_idx;
   reg_idx_t ex_dest_idx;
   word_t    ex_rs_val;
   word_t    ex_rt_val;
   word_t    ex_imm;
   alu_op_t  ex_alu_op;
   logic     ex_use_imm;
   logic     ex_dest_we;
   logic     ex_is_load;
   logic     ex_is_store;
   logic     ex_is_halt;

   // EX/MEM
   word_t    mem_alu_res;
   word_t    mem_store_val;
   reg_idx_t mem_dest_idx;
   logic     mem_dest_we;
   logic     mem_is_load;
   logic     mem_is_store;
   logic     mem_is_halt;

   // Writeback, shared by register file and forwarding
   logic     wb_we;
   reg_idx_t wb_idx;
   word_t    wb_data;

   //////////////////////////////
   // Pipeline stages
   //////////////////////////////

   fetch_stage u_fetch (
      .clk       (clk),
      .rst_n     (rst_n),
      .stall_i   (stall),
      .halt_id_i (halt_id),
      .iaddr_o   (iaddr_o),
      .inst_i    (inst_i),
      .if_inst_o (if_inst)
   );

   decode_stage u_decode (
      .clk           (clk),
      .rst_n         (rst_n),
      .if_inst_i     (if_inst),
      .stall_o       (stall),
      .halt_id_o     (halt_id),
      .err_o         (err_o),
      .wb_we_i       (wb_we),
      .wb_idx_i      (wb_idx),
      .wb_data_i     (wb_data),
      .ex_rs_idx_o   (ex_rs_idx),
      .ex_rt_idx_o   (ex_rt_idx),
      .ex_dest_idx_o (ex_dest_idx),
      .ex_rs_val_o   (ex_rs_val),
      .ex_rt_val_o   (ex_rt_val),
      .ex_imm_o      (ex_imm),
      .ex_alu_op_o   (ex_alu_op),
      .ex_use_imm_o  (ex_use_imm),
      .ex_dest_we_o  (ex_dest_we),
      .ex_is_load_o  (ex_is_load),
      .ex_is_store_o (ex_is_store),
      .ex_is_halt_o  (ex_is_halt)
   );

   execute_stage u_execute (
      .clk             (clk),
      .rst_n           (rst_n),
      .ex_rs_idx_i     (ex_rs_idx),
      .ex_rt_idx_i     (ex_rt_idx),
      .ex_dest_idx_i   (ex_dest_idx),
      .ex_rs_val_i     (ex_rs_val),
      .ex_rt_val_i     (ex_rt_val),
      .ex_imm_i        (ex_imm),
      .ex_alu_op_i     (ex_alu_op),
      .ex_use_imm_i    (ex_use_imm),
      .ex_dest_we_i    (ex_dest_we),
      .ex_is_load_i    (ex_is_load),
      .ex_is_store_i   (ex_is_store),
      .ex_is_halt_i    (ex_is_halt),
      .wb_we_i         (wb_we),
      .wb_idx_i        (wb_idx),
      .wb_data_i       (wb_data),
      .mem_alu_res_o   (mem_alu_res),
      .mem_store_val_o (mem_store_val),
      .mem_dest_idx_o  (mem_dest_idx),
      .mem_dest_we_o   (mem_dest_we),
      .mem_is_load_o   (mem_is_load),
      .mem_is_store_o  (mem_is_store),
      .mem_is_halt_o   (mem_is_halt)
   );

   mem_wb_stage u_mem_wb (
      .clk             (clk),
      .rst_n           (rst_n),
      .mem_alu_res_i   (mem_alu_res),
      .mem_store_val_i (mem_store_val),
      .mem_dest_idx_i  (mem_dest_idx),
      .mem_dest_we_i   (mem_dest_we),
      .mem_is_load_i   (mem_is_load),
      .mem_is_store_i  (mem_is_store),
      .mem_is_halt_i   (mem_is_halt),
      .daddr_o         (daddr_o),
      .data_o          (data_o),
      .we_o            (we_o),
      .re_o            (re_o),
      .rdata_i         (rdata_i),
      .wb_we_o         (wb_we),
      .wb_idx_o        (wb_idx),
      .wb_data_o       (wb_data),
      .halt_o          (halt_o)
   );

endmodule

// File: verification/tb_memory.sv
`timescale 1ns/1ps

module tb_memory #(
   parameter int PROG_WORDS = 512,
   parameter int DATA_WORDS = 64
) (
   input  logic           clk,
   input  logic           rst_n,
   input  isa_pkg::word_t iaddr_i,
   output isa_pkg::word_t inst_o,
   input  isa_pkg::word_t daddr_i,
   input  isa_pkg::word_t wdata_i,
   input  logic           we_i,
   output isa_pkg::word_t rdata_o,
   output isa_pkg::word_t store_cnt_o
);
   import isa_pkg::*;

   localparam int PROG_AW = $clog2(PROG_WORDS);
   localparam int DATA_AW = $clog2(DATA_WORDS);

   // Program image, loaded by the testbench while the core is in reset
   word_t imem [PROG_WORDS];
   word_t dmem [DATA_WORDS];
   logic  in_prog;

   //////////////////////////////
   // Combinational read ports
   //////////////////////////////

   // Fetches past the image return NOP
   assign in_prog = (iaddr_i >> (PROG_AW + 2)) == '0;
   assign inst_o  = in_prog ? imem[iaddr_i[PROG_AW+1:2]] : '0;

   // Data addresses wrap on the word index
   assign rdata_o = dmem[daddr_i[DATA_AW+1:2]];

   //////////////////////////////
   // Store port
   //////////////////////////////

   // Data starts at zero for every run, stores are counted in order
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < DATA_WORDS; i++) begin
            dmem[i] <= '0;
         end
         store_cnt_o <= '0;
      end else if (we_i) begin
         dmem[daddr_i[DATA_AW+1:2]] <= wdata_i;
         store_cnt_o                <= store_cnt_o + word_t'(1);
      end
   end

endmodule

// File: verification/proc_tb.sv
`timescale 1ns/1ps
`include "proc_defs.svh"

module proc_tb;
   import isa_pkg::*;

   localparam int PROG_WORDS   = 512;
   localparam int DATA_WORDS   = 64;
   localparam int HALT_TIMEOUT = 2000;

   logic  clk;
   logic  rst_n;
   word_t iaddr;
   word_t inst;
   word_t daddr;
   word_t wdata;
   logic  we;
   logic  re;
   word_t rdata;
   logic  err;
   logic  halt;
   word_t store_cnt;

   // Program under construction and the predictions for it
   word_t lcg_state;
   word_t prog [PROG_WORDS];
   int    prog_len;
   word_t exp_addr [PROG_WORDS];
   word_t exp_data [PROG_WORDS];
   word_t exp_count;
   word_t model_mem [DATA_WORDS];
   word_t cur_addr;
   word_t cur_data;
   word_t err_cycles;

   // One counter per checker
   int reset_fails  = 0;
   int addr_fails   = 0;
   int data_fails   = 0;
   int extra_fails  = 0;
   int sticky_fails = 0;
   int quiet_fails  = 0;
   int check_fails  = 0;
   int tests_run    = 0;
   int tests_failed = 0;

   proc UUT (
      .clk     (clk),
      .rst_n   (rst_n),
      .iaddr_o (iaddr),
      .inst_i  (inst),
      .daddr_o (daddr),
      .data_o  (wdata),
      .we_o    (we),
      .re_o    (re),
      .rdata_i (rdata),
      .err_o   (err),
      .halt_o  (halt)
   );

   tb_memory #(
      .PROG_WORDS (PROG_WORDS),
      .DATA_WORDS (DATA_WORDS)
   ) u_memory (
      .clk         (clk),
      .rst_n       (rst_n),
      .iaddr_i     (iaddr),
      .inst_o      (inst),
      .daddr_i     (daddr),
      .wdata_i     (wdata),
      .we_i        (we),
      .rdata_o     (rdata),
      .store_cnt_o (store_cnt)
   );

   always #50 clk = ~clk;

   // Next store the model expects
   assign cur_addr = exp_addr[store_cnt[8:0]];
   assign cur_data = exp_data[store_cnt[8:0]];

   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         err_cycles <= '0;
      end else if (err) begin
         err_cycles <= err_cycles + word_t'(1);
      end
   end

   //////////////////////////////
   // Assertions
   //////////////////////////////

   a_reset_idle: assert property (@(posedge clk)
      (!rst_n || $rose(rst_n)) |-> (!we && !re && !halt && !err && (iaddr == '0)))
      else begin
         reset_fails++;
         $display("%0t: core outputs not idle during or right after reset", $time);
      end

   a_store_addr: assert property (@(posedge clk) disable iff (!rst_n)
      (we && (store_cnt < exp_count)) |-> (daddr == cur_addr))
      else begin
         addr_fails++;
         $display("MISMATCH time=%0t signal=daddr_o expected=%h actual=%h",
                  $time, cur_addr, daddr);
      end

   a_store_data: assert property (@(posedge clk) disable iff (!rst_n)
      (we && (store_cnt < exp_count)) |-> (wdata == cur_data))
      else begin
         data_fails++;
         $display("MISMATCH time=%0t signal=data_o expected=%h actual=%h",
                  $time, cur_data, wdata);
      end

   a_store_expected: assert property (@(posedge clk) disable iff (!rst_n)
      we |-> (store_cnt < exp_count))
      else begin
         extra_fails++;
         $display("%0t: store on the data port that the model does not predict", $time);
      end

   a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
      halt |=> halt)
      else begin
         sticky_fails++;
         $display("%0t: halt_o dropped while out of reset", $time);
      end

   // Halted core touches no memory and fetches from a fixed address
   a_halted_quiet: assert property (@(posedge clk) disable iff (!rst_n)
      halt |-> (!we && !re && $stable(iaddr)))
      else begin
         quiet_fails++;
         $display("%0t: memory access or fetch movement after halt", $time);
      end

   function automatic int total_fails();
      return reset_fails + addr_fails + data_fails + extra_fails +
             sticky_fails + quiet_fails + check_fails;
   endfunction

   //////////////////////////////
   // Program construction
   //////////////////////////////

   function automatic word_t next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic word_t r_format(opcode_t op, int rd, int rs, int rt);
      return {op, 5'(rs), 5'(rt), 5'(rd), 11'd0};
   endfunction

   function automatic word_t i_format(opcode_t op, int rt, int rs, int imm);
      return {op, 5'(rs), 5'(rt), 16'(imm)};
   endfunction

   task automatic emit(input word_t w);
      prog[prog_len] = w;
      prog_len++;
   endtask

   task automatic start_program();
      for (int i = 0; i < PROG_WORDS; i++) begin
         prog[i] = '0;
      end
      prog_len = 0;
   endtask

   // Dump r1 to r7 above the scratch area, then stop
   task automatic finish_program();
      for (int r = 1; r < 8; r++) begin
         emit(i_format(OP_ST, r, 0, 4 * (16 + r)));
      end
      emit({OP_HALT, 26'd0});
   endtask

   task automatic build_random(input int count);
      word_t r;
      int    rd;
      int    rs;
      int    rt;
      int    off;
      int    imm;
      for (int k = 1; k < 8; k++) begin
         r = next_rand();
         emit(i_format(OP_ADDI, k, 0, int'(r[15:0])));
      end
      for (int k = 0; k < count; k++) begin
         r   = next_rand();
         rd  = int'(r[4:2]);
         rs  = int'(r[7:5]);
         rt  = int'(r[10:8]);
         off = 4 * int'(r[14:11]);
         imm = int'(r[23:16]) - 128;
         case (r[30:28])
            3'd0: emit(r_format(OP_ADD, rd, rs, rt));
            3'd1: emit(r_format(OP_SUB, rd, rs, rt));
            3'd2: emit(r_format(OP_AND, rd, rs, rt));
            3'd3: emit(r_format(OP_XOR, rd, rs, rt));
            3'd5: emit(i_format(OP_LD, rd, 0, off));
            3'd6: emit(i_format(OP_ST, rt, 0, off));
            default: emit(i_format(OP_ADDI, rd, rs, imm));
         endcase
      end
   endtask

   //////////////////////////////
   // Instruction-set model
   //////////////////////////////

   task automatic run_model();
      word_t    regs [`PROC_NUM_REGS];
      word_t    w;
      word_t    a;
      word_t    b;
      word_t    imm;
      word_t    addr;
      opcode_t  op;
      reg_idx_t rs;
      reg_idx_t rt;
      reg_idx_t rd;
      int       pc;
      bit       done;
      for (int i = 0; i < `PROC_NUM_REGS; i++) begin
         regs[i] = '0;
      end
      for (int i = 0; i < DATA_WORDS; i++) begin
         model_mem[i] = '0;
      end
      exp_count = '0;
      pc        = 0;
      done      = 1'b0;
      while (!done && (pc < prog_len)) begin
         w    = prog[pc];
         op   = opcode_t'(w[`PROC_OPC_LSB +: `PROC_OPC_W]);
         rs   = w[`PROC_RS_LSB +: `PROC_REG_IDX_W];
         rt   = w[`PROC_RT_LSB +: `PROC_REG_IDX_W];
         rd   = w[`PROC_RD_LSB +: `PROC_REG_IDX_W];
         imm  = {{(`PROC_WORD_W-`PROC_IMM_W){w[`PROC_IMM_W-1]}}, w[`PROC_IMM_W-1:0]};
         a    = regs[rs];
         b    = regs[rt];
         addr = a + imm;
         case (op)
            OP_HALT: done = 1'b1;
            OP_ADD:  regs[rd] = a + b;
            OP_SUB:  regs[rd] = a - b;
            OP_AND:  regs[rd] = a & b;
            OP_XOR:  regs[rd] = a ^ b;
            OP_ADDI: regs[rt] = addr;
            OP_LD:   regs[rt] = model_mem[addr[7:2]];
            OP_ST: begin
               model_mem[addr[7:2]]    = b;
               exp_addr[exp_count[8:0]] = addr;
               exp_data[exp_count[8:0]] = b;
               exp_count++;
            end
            // NOP and undefined opcodes change nothing
            default: ;
         endcase
         regs[0] = '0;
         pc++;
      end
   endtask

   //////////////////////////////
   // Running and reporting
   //////////////////////////////

   task automatic check_results(input bit expect_err);
      assert (store_cnt == exp_count) else begin
         check_fails++;
         $display("MISMATCH time=%0t signal=store_count expected=%0d actual=%0d",
                  $time, exp_count, store_cnt);
      end
      for (int i = 0; i < DATA_WORDS; i++) begin
         assert (u_memory.dmem[i] == model_mem[i]) else begin
            check_fails++;
            $display("MISMATCH time=%0t signal=dmem[%0d] expected=%h actual=%h",
                     $time, i, model_mem[i], u_memory.dmem[i]);
         end
      end
      if (expect_err) begin
         assert (err_cycles != '0) else begin
            check_fails++;
            $display("%0t: err_o never rose for the undefined opcode", $time);
         end
      end else begin
         assert (err_cycles == '0) else begin
            check_fails++;
            $display("%0t: err_o rose in a program of legal opcodes", $time);
         end
      end
   endtask

   task automatic run_test(input string name, input bit expect_err);
      int fails_before;
      int cyc;
      fails_before = total_fails();
      @(posedge clk);
      #1 rst_n = 1'b0;
      for (int i = 0; i < PROG_WORDS; i++) begin
         u_memory.imem[i] = prog[i];
      end
      run_model();
      repeat (10) @(posedge clk);
      #1 rst_n = 1'b1;
      cyc = 0;
      while (!halt && (cyc < HALT_TIMEOUT)) begin
         @(posedge clk);
         #1;
         cyc++;
      end
      if (!halt) begin
         $display("test %s: halt_o not raised within %0d cycles", name, HALT_TIMEOUT);
         $display("Simulation FAILED");
         $finish;
      end else begin
         // Keep watching the halted core
         repeat (20) @(posedge clk);
         #1;
         check_results(expect_err);
         tests_run++;
         if (total_fails() == fails_before) begin
            $display("test %s: ok, %0d stores", name, store_cnt);
         end else begin
            tests_failed++;
            $display("test %s: error", name);
         end
      end
   endtask

   initial begin
      clk       = 1'b0;
      rst_n     = 1'b0;
      lcg_state = 32'ha7e2d96d;
      exp_count = '0;

      // Idle core, only the register dump
      start_program();
      emit('0);
      emit('0);
      finish_program();
      run_test("reset_idle", 1'b0);

      // Back-to-back dependencies through MEM, WB and the register file
      start_program();
      emit(i_format(OP_ADDI, 1, 0, 7));
      emit(r_format(OP_ADD, 2, 1, 1));
      emit(r_format(OP_SUB, 3, 2, 1));
      emit(r_format(OP_AND, 4, 3, 2));
      emit(r_format(OP_XOR, 5, 4, 1));
      emit(i_format(OP_ADDI, 6, 5, -3));
      emit(r_format(OP_ADD, 0, 6, 6));
      emit(r_format(OP_ADD, 7, 0, 6));
      emit(i_format(OP_ADDI, 1, 1, 100));
      emit(i_format(OP_ST, 1, 0, 0));
      emit('0);
      emit(r_format(OP_ADD, 2, 1, 3));
      emit('0);
      emit('0);
      emit(r_format(OP_SUB, 3, 1, 2));
      emit(r_format(OP_XOR, 4, 3, 3));
      finish_program();
      run_test("dependency_chain", 1'b0);

      // Load-use stalls on rs and rt, and a load feeding store data
      start_program();
      emit(i_format(OP_ADDI, 1, 0, 'h55));
      emit(i_format(OP_ADDI, 2, 0, -9));
      emit(i_format(OP_ST, 1, 0, 4));
      emit(i_format(OP_ST, 2, 0, 8));
      emit(i_format(OP_LD, 3, 0, 4));
      emit(r_format(OP_ADD, 4, 3, 2));
      emit(i_format(OP_LD, 5, 0, 8));
      emit(i_format(OP_ST, 5, 0, 12));
      emit(i_format(OP_LD, 6, 0, 12));
      emit(r_format(OP_SUB, 7, 1, 6));
      emit(i_format(OP_LD, 1, 0, 16));
      emit(i_format(OP_LD, 2, 1, 4));
      finish_program();
      run_test("load_use", 1'b0);

      start_program();
      build_random(200);
      finish_program();
      run_test("random_mix", 1'b0);

      // Instructions after HALT must never run
      start_program();
      emit(i_format(OP_ADDI, 3, 0, 33));
      finish_program();
      emit(i_format(OP_ST, 3, 0, 0));
      emit(i_format(OP_LD, 4, 0, 0));
      emit(i_format(OP_ST, 3, 0, 4));
      run_test("halt_stops", 1'b0);

      // Undefined opcodes between live instructions
      start_program();
      emit(i_format(OP_ADDI, 1, 0, 5));
      emit({6'h3f, 5'd1, 5'd2, 16'h1234});
      emit(r_format(OP_ADD, 2, 1, 1));
      emit({6'h2a, 5'd2, 5'd2, 5'd2, 11'd0});
      emit(r_format(OP_SUB, 3, 2, 1));
      finish_program();
      run_test("undefined_opcode", 1'b1);

      $display("tests run %0d, tests failed %0d, failed checks %0d",
               tests_run, tests_failed, total_fails());
      if (total_fails() == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

// File: tb.f
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/fetch_stage.sv
src/reg_file.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/proc.sv
verification/tb_memory.sv
verification/proc_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the processor testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f tb.f --top-module proc_tb -o sim_proc_tb
status=$?
if [ "$status" -ne 0 ]; then
   echo "Verilator compilation failed with status $status"
   exit 1
fi

output="$(./obj_dir/sim_proc_tb 2>&1)"
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
   echo "Simulation binary exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Simulation PASSED"; then
   exit 0
else
   exit 1
fi
